/* gamePkg.sv */
package gamePkg;

	// pixel coordinates, colour and frame-buffer address
	typedef logic [7:0] xCoord;
	typedef logic [6:0] yCoord;
	typedef logic [2:0] pixelColor;
	typedef logic [14:0] fbAddr;

	// one byte from the keyboard
	typedef logic [7:0] scanCode;

	typedef enum logic [2:0] {
		cmdLeft,
		cmdRight,
		cmdUp,
		cmdDown,
		cmdShoot
	} keyCmd;

	// screen geometry
	localparam int screenWidth = 160;
	localparam int screenHeight = 120;

	// cursor limits and start point
	localparam yCoord cursorMinY = 7'd20;
	localparam xCoord cursorStartX = 8'd80;
	localparam yCoord cursorStartY = 7'd60;

	// target square side, also the timer bar segment size
	localparam int targetSize = 5;
	localparam yCoord timerRow = 7'd11;
	localparam int timerStep = 5;

	// 3-bit RGB
	localparam pixelColor colorBlack = 3'd0;
	localparam pixelColor colorGreen = 3'd2;
	localparam pixelColor colorCyan = 3'd3;
	localparam pixelColor colorYellow = 3'd6;

	// make codes of the arrow keys and space
	localparam scanCode codeLeft = 8'h6B;
	localparam scanCode codeRight = 8'h74;
	localparam scanCode codeUp = 8'h75;
	localparam scanCode codeDown = 8'h72;
	localparam scanCode codeShoot = 8'h29;

	// target hops through these slots, wrapping after the last
	localparam int numSlots = 7;
	localparam xCoord targetSlotX [numSlots] = '{
		8'd25, 8'd55, 8'd85, 8'd25, 8'd55, 8'd85, 8'd55
	};
	localparam yCoord targetSlotY [numSlots] = '{
		7'd25, 7'd25, 7'd25, 7'd75, 7'd75, 7'd75, 7'd50
	};

endpackage

/* pixelStreamIf.sv */
`timescale 1ns/10ps

interface pixelStreamIf;
	import gamePkg::*;

	logic valid;
	logic ready;
	xCoord x;
	yCoord y;
	pixelColor color;

	// producer side of a pixel write
	modport source (output valid, output x, output y, output color, input ready);

	// consumer side
	modport sink (input valid, input x, input y, input color, output ready);

endinterface

/* keyDecoder.sv */
`timescale 1ns/10ps

module keyDecoder (
	input logic clk,
	input logic resetn,
	input gamePkg::scanCode scanData,
	input logic scanValid,
	input logic cmdReady,
	output logic scanReady,
	output logic cmdValid,
	output gamePkg::keyCmd cmd
);
	import gamePkg::*;

	keyCmd decoded;
	logic known;
	logic accept;

	// map the five game keys, anything else is dropped
	always_comb
	begin
		decoded = cmdLeft;
		known = 1'b1;
		case (scanData)
			codeLeft: decoded = cmdLeft;
			codeRight: decoded = cmdRight;
			codeUp: decoded = cmdUp;
			codeDown: decoded = cmdDown;
			codeShoot: decoded = cmdShoot;
			default: known = 1'b0;
		endcase
	end

	// single holding slot
	assign scanReady = !cmdValid;
	assign accept = scanValid && scanReady;

	always_ff @(posedge clk)
	begin
		if (!resetn)
			cmdValid <= 1'b0;
		else if (accept && known)
			cmdValid <= 1'b1;
		else if (cmdValid && cmdReady)
			cmdValid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			cmd <= decoded;
	end

endmodule

/* gameEngine.sv */
`timescale 1ns/10ps

module gameEngine #(
	parameter int tickPeriod = 1000000
) (
	input logic clk,
	input logic resetn,
	input logic start,
	input logic cmdValid,
	input gamePkg::keyCmd cmd,
	output logic cmdReady,
	output logic won,
	output logic lost,
	pixelStreamIf.source pix
);
	import gamePkg::*;

	typedef enum logic [3:0] {
		stIdle,
		stIntroTarget,
		stIntroCursor,
		stPlay,
		stMoveErase,
		stMoveDraw,
		stShoot,
		stTickErase,
		stTickBar,
		stTickDraw,
		stWon,
		stLost
	} engineState;

	engineState state;
	xCoord curX;
	yCoord curY;
	xCoord oldX;
	yCoord oldY;
	xCoord newX;
	yCoord newY;
	xCoord slotX;
	yCoord slotY;
	xCoord timerPos;
	xCoord nextTimer;
	logic [2:0] slot;
	logic [2:0] cx;
	logic [2:0] cy;
	logic [31:0] tickCount;
	logic tickFire;
	logic moveOk;
	logic hit;
	logic pixDone;
	logic sweeping;
	logic sweepLast;

	assign slotX = targetSlotX[slot];
	assign slotY = targetSlotY[slot];
	assign nextTimer = xCoord'(timerPos + xCoord'(timerStep));

	// cursor inside the 5x5 target square
	assign hit = (curX >= slotX) && (curX <= xCoord'(slotX + xCoord'(targetSize - 1)))
		&& (curY >= slotY) && (curY <= yCoord'(slotY + yCoord'(targetSize - 1)));

	// tick wins over a pending key
	assign tickFire = (state == stPlay) && (tickCount == 32'(tickPeriod - 1));
	assign cmdReady = ((state == stPlay) && !tickFire) || (state == stWon) || (state == stLost);
	assign won = (state == stWon);
	assign lost = (state == stLost);

	assign pixDone = pix.valid && pix.ready;
	assign sweeping = (state == stIntroTarget) || (state == stTickErase)
		|| (state == stTickBar) || (state == stTickDraw);
	assign sweepLast = (cx == 3'(targetSize - 1)) && (cy == 3'(targetSize - 1));

	// next cursor position and bound check for a move key
	always_comb
	begin
		newX = curX;
		newY = curY;
		moveOk = 1'b0;
		case (cmd)
			cmdLeft:
			begin
				newX = curX - 8'd1;
				moveOk = (curX != '0);
			end
			cmdRight:
			begin
				newX = curX + 8'd1;
				moveOk = (curX != xCoord'(screenWidth - 1));
			end
			cmdUp:
			begin
				newY = curY - 7'd1;
				moveOk = (curY != cursorMinY);
			end
			cmdDown:
			begin
				newY = curY + 7'd1;
				moveOk = (curY != yCoord'(screenHeight - 1));
			end
			default: ;
		endcase
	end

	// pixel write for the current state, held until it transfers
	always_comb
	begin
		pix.valid = 1'b1;
		pix.x = curX;
		pix.y = curY;
		pix.color = colorYellow;
		case (state)
			stIntroTarget, stTickDraw:
			begin
				pix.x = xCoord'(slotX + xCoord'(cx));
				pix.y = yCoord'(slotY + yCoord'(cy));
				pix.color = colorCyan;
			end
			stTickErase:
			begin
				pix.x = xCoord'(slotX + xCoord'(cx));
				pix.y = yCoord'(slotY + yCoord'(cy));
				pix.color = colorBlack;
			end
			stTickBar:
			begin
				pix.x = xCoord'(timerPos + xCoord'(cx));
				pix.y = yCoord'(timerRow + yCoord'(cy));
				pix.color = colorBlack;
			end
			stMoveErase:
			begin
				pix.x = oldX;
				pix.y = oldY;
				pix.color = colorBlack;
			end
			stIntroCursor, stMoveDraw: pix.color = colorYellow;
			stShoot: pix.color = colorGreen;
			default: pix.valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state <= stIdle;
			curX <= cursorStartX;
			curY <= cursorStartY;
			slot <= '0;
			timerPos <= '0;
			cx <= '0;
			cy <= '0;
			tickCount <= '0;
		end
		else
		begin
			// row-major sweep, x fastest
			if (pixDone && sweeping)
			begin
				if (cx == 3'(targetSize - 1))
				begin
					cx <= '0;
					if (cy == 3'(targetSize - 1))
						cy <= '0;
					else
						cy <= cy + 3'd1;
				end
				else
					cx <= cx + 3'd1;
			end

			case (state)
				stIdle:
					if (start)
						state <= stIntroTarget;
				stIntroTarget:
					if (pixDone && sweepLast)
						state <= stIntroCursor;
				stIntroCursor:
					if (pixDone)
						state <= stPlay;
				stPlay:
				begin
					if (tickFire)
					begin
						tickCount <= '0;
						state <= stTickErase;
					end
					else
					begin
						tickCount <= tickCount + 32'd1;
						if (cmdValid && cmd == cmdShoot)
							state <= stShoot;
						else if (cmdValid && moveOk)
						begin
							oldX <= curX;
							oldY <= curY;
							curX <= newX;
							curY <= newY;
							state <= stMoveErase;
						end
					end
				end
				stMoveErase:
					if (pixDone)
						state <= stMoveDraw;
				stMoveDraw:
					if (pixDone)
						state <= stPlay;
				stShoot:
					if (pixDone)
						state <= hit ? stWon : stPlay;
				stTickErase:
					if (pixDone && sweepLast)
						state <= stTickBar;
				stTickBar:
				begin
					if (pixDone && sweepLast)
					begin
						timerPos <= nextTimer;
						// bar fully erased means the player ran out of time
						if (nextTimer == xCoord'(screenWidth))
							state <= stLost;
						else
						begin
							slot <= (slot == 3'(numSlots - 1)) ? 3'd0 : slot + 3'd1;
							state <= stTickDraw;
						end
					end
				end
				stTickDraw:
					if (pixDone && sweepLast)
						state <= stPlay;
				stWon, stLost: ;
				default: state <= stIdle;
			endcase
		end
	end

endmodule

/* pixelFifo.sv */
`timescale 1ns/10ps

module pixelFifo #(
	parameter int depth = 16
) (
	input logic clk,
	input logic resetn,
	pixelStreamIf.sink inPix,
	pixelStreamIf.source outPix
);
	import gamePkg::*;

	xCoord memX [depth];
	yCoord memY [depth];
	pixelColor memColor [depth];
	logic [$clog2(depth)-1:0] wrPtr;
	logic [$clog2(depth)-1:0] rdPtr;
	logic [$clog2(depth):0] count;
	logic push;
	logic pop;

	assign inPix.ready = (count != ($clog2(depth) + 1)'(depth));
	assign outPix.valid = (count != '0);
	assign outPix.x = memX[rdPtr];
	assign outPix.y = memY[rdPtr];
	assign outPix.color = memColor[rdPtr];

	assign push = inPix.valid && inPix.ready;
	assign pop = outPix.valid && outPix.ready;

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			memX[wrPtr] <= inPix.x;
			memY[wrPtr] <= inPix.y;
			memColor[wrPtr] <= inPix.color;
		end
	end

	// pointers wrap at depth
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == ($clog2(depth))'(depth - 1))
					? '0 : wrPtr + ($clog2(depth))'(1);
			if (pop)
				rdPtr <= (rdPtr == ($clog2(depth))'(depth - 1))
					? '0 : rdPtr + ($clog2(depth))'(1);
			if (push && !pop)
				count <= count + ($clog2(depth) + 1)'(1);
			else if (pop && !push)
				count <= count - ($clog2(depth) + 1)'(1);
		end
	end

endmodule

/* framePlotter.sv */
`timescale 1ns/10ps

module framePlotter (
	input logic clk,
	input logic resetn,
	input logic plotReady,
	pixelStreamIf.sink pix,
	output gamePkg::fbAddr plotAddr,
	output gamePkg::pixelColor plotColor,
	output logic plotValid
);
	import gamePkg::*;

	fbAddr rowBase;
	fbAddr addr;
	logic accept;

	// take a new write when the output register is empty or leaving
	assign pix.ready = !plotValid || plotReady;
	assign accept = pix.valid && pix.ready;

	// linear address y*160 + x
	assign rowBase = fbAddr'(pix.y) * fbAddr'(screenWidth);
	assign addr = rowBase + fbAddr'(pix.x);

	always_ff @(posedge clk)
	begin
		if (!resetn)
			plotValid <= 1'b0;
		else if (accept)
			plotValid <= 1'b1;
		else if (plotReady)
			plotValid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			plotAddr <= addr;
			plotColor <= pix.color;
		end
	end

endmodule

/* targetGame.sv */
`timescale 1ns/10ps

module targetGame #(
	parameter int tickPeriod = 1000000
) (
	input logic clk,
	input logic resetn,
	input logic start,
	input gamePkg::scanCode scanData,
	input logic scanValid,
	input logic plotReady,
	output logic scanReady,
	output gamePkg::fbAddr plotAddr,
	output gamePkg::pixelColor plotColor,
	output logic plotValid,
	output logic won,
	output logic lost
);
	import gamePkg::*;

	keyCmd cmd;
	logic cmdValid;
	logic cmdReady;

	// engine to FIFO, FIFO to plotter
	pixelStreamIf enginePix ();
	pixelStreamIf plotPix ();

	keyDecoder u_keyDecoder (
		.clk(clk),
		.resetn(resetn),
		.scanData(scanData),
		.scanValid(scanValid),
		.cmdReady(cmdReady),
		.scanReady(scanReady),
		.cmdValid(cmdValid),
		.cmd(cmd)
	);

	gameEngine #(.tickPeriod(tickPeriod)) u_gameEngine (
		.clk(clk),
		.resetn(resetn),
		.start(start),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.cmdReady(cmdReady),
		.won(won),
		.lost(lost),
		.pix(enginePix.source)
	);

	pixelFifo #(.depth(16)) u_pixelFifo (
		.clk(clk),
		.resetn(resetn),
		.inPix(enginePix.sink),
		.outPix(plotPix.source)
	);

	framePlotter u_framePlotter (
		.clk(clk),
		.resetn(resetn),
		.plotReady(plotReady),
		.pix(plotPix.sink),
		.plotAddr(plotAddr),
		.plotColor(plotColor),
		.plotValid(plotValid)
	);

endmodule

/* tb_targetGame.sv */
`timescale 1ns/10ps

module tb_targetGame;
	import gamePkg::*;

	localparam int keyTickPeriod = 1000000;
	localparam int fastTickPeriod = 20;
	localparam int randomKeys = 300;
	localparam int boundKeys = 85 + 165 + 45 + 105;
	localparam int shootKeys = 1 + 53 + 33 + 1 + 4;
	localparam int numTicks = 32;
	localparam int quietCycles = 50;

	// per-item cycle budgets with room for the halved throughput under random ready
	localparam int cyclesPerKey = 40;
	localparam int cyclesPerTick = fastTickPeriod + 75 * 4 + 10;
	localparam int phaseOverhead = 3 + 26 * 4 + quietCycles + 20;
	localparam int cycleLimit = 2 * (boundKeys + randomKeys) * cyclesPerKey
		+ shootKeys * cyclesPerKey + 2 * numTicks * cyclesPerTick + 7 * phaseOverhead;

	localparam int kindLeft = 0;
	localparam int kindRight = 1;
	localparam int kindUp = 2;
	localparam int kindDown = 3;
	localparam int kindShoot = 4;
	localparam int kindOther = 5;

	localparam int slotXs [7] = '{25, 55, 85, 25, 55, 85, 55};
	localparam int slotYs [7] = '{25, 25, 25, 75, 75, 75, 50};

	logic clk;
	logic resetn;
	logic start;
	scanCode scanData;
	logic scanValid;
	logic plotReady;

	logic dutScanReady;
	fbAddr keyAddr;
	pixelColor keyColor;
	logic keyValid;
	logic keyWon;
	logic keyLost;
	fbAddr tickAddr;
	pixelColor tickColor;
	logic tickValid;
	logic tickWon;
	logic tickLost;
	logic tickScanReady;

	// outputs of whichever DUT the current phase watches
	logic useTick;
	fbAddr obsAddr;
	pixelColor obsColor;
	logic obsValid;
	logic obsWon;
	logic obsLost;
	logic obsScanReady;

	logic randomReady;
	logic [31:0] lfsrState;
	int errorCount = 0;
	int cycleCount = 0;

	// random key kinds of the first key phase, replayed under back-pressure
	int keyKinds [randomKeys];

	fbAddr expAddr [$];
	pixelColor expColor [$];
	int mCurX;
	int mCurY;
	int mSlot;
	int mTimer;
	logic mWon;
	logic mLost;

	// key phases never see a tick here
	targetGame #(.tickPeriod(keyTickPeriod)) u_dut (
		.clk(clk),
		.resetn(resetn),
		.start(start),
		.scanData(scanData),
		.scanValid(scanValid),
		.plotReady(plotReady),
		.scanReady(dutScanReady),
		.plotAddr(keyAddr),
		.plotColor(keyColor),
		.plotValid(keyValid),
		.won(keyWon),
		.lost(keyLost)
	);

	// short tick period for the timer phases without keys
	targetGame #(.tickPeriod(fastTickPeriod)) u_tickDut (
		.clk(clk),
		.resetn(resetn),
		.start(start),
		.scanData(8'h00),
		.scanValid(1'b0),
		.plotReady(plotReady),
		.scanReady(tickScanReady),
		.plotAddr(tickAddr),
		.plotColor(tickColor),
		.plotValid(tickValid),
		.won(tickWon),
		.lost(tickLost)
	);

	assign obsAddr = useTick ? tickAddr : keyAddr;
	assign obsColor = useTick ? tickColor : keyColor;
	assign obsValid = useTick ? tickValid : keyValid;
	assign obsWon = useTick ? tickWon : keyWon;
	assign obsLost = useTick ? tickLost : keyLost;
	assign obsScanReady = useTick ? tickScanReady : dutScanReady;

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: no progress within %0d cycles", cycleLimit);
			stopOnError();
		end
	end

	task automatic stopOnError();
		errorCount++;
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkAddr(input fbAddr got, input fbAddr exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s was %0d, expected %0d", $time, what, got, exp);
			stopOnError();
		end
	endtask

	task automatic checkColor(input pixelColor got, input pixelColor exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s was %0d, expected %0d", $time, what, got, exp);
			stopOnError();
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s was %b, expected %b", $time, what, got, exp);
			stopOnError();
		end
	endtask

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic int takeBits(input int n);
		int v;
		int i;
		v = 0;
		for (i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			v = (v << 1) | int'(lfsrState[0]);
		end
		return v;
	endfunction

	function automatic int randomKind();
		int v;
		v = takeBits(3);
		return (v < 5) ? v : kindOther;
	endfunction

	function automatic scanCode codeFor(input int kind);
		scanCode c;
		case (kind)
			kindLeft: c = codeLeft;
			kindRight: c = codeRight;
			kindUp: c = codeUp;
			kindDown: c = codeDown;
			kindShoot: c = codeShoot;
			default:
			begin
				c = scanCode'(takeBits(8));
				if (c == codeLeft || c == codeRight || c == codeUp || c == codeDown
					|| c == codeShoot)
					c = 8'h00;
			end
		endcase
		return c;
	endfunction

	task automatic expectPixel(input int x, input int y, input pixelColor c);
		expAddr.push_back(fbAddr'(y * 160 + x));
		expColor.push_back(c);
	endtask

	// 5x5 square row by row with x fastest
	task automatic drawSquare(input int x0, input int y0, input pixelColor c);
		int i;
		int j;
		for (j = 0; j < 5; j++)
			for (i = 0; i < 5; i++)
				expectPixel(x0 + i, y0 + j, c);
	endtask

	task automatic modelKey(input int kind);
		int nx;
		int ny;
		logic blocked;
		nx = mCurX;
		ny = mCurY;
		blocked = 1'b0;
		if (!mWon && !mLost)
		begin
			if (kind == kindShoot)
			begin
				expectPixel(mCurX, mCurY, colorGreen);
				if (mCurX >= slotXs[mSlot] && mCurX <= slotXs[mSlot] + 4
					&& mCurY >= slotYs[mSlot] && mCurY <= slotYs[mSlot] + 4)
					mWon = 1'b1;
			end
			else if (kind != kindOther)
			begin
				case (kind)
					kindLeft:
					begin
						blocked = (mCurX == 0);
						nx = mCurX - 1;
					end
					kindRight:
					begin
						blocked = (mCurX == 159);
						nx = mCurX + 1;
					end
					kindUp:
					begin
						blocked = (mCurY == 20);
						ny = mCurY - 1;
					end
					default:
					begin
						blocked = (mCurY == 119);
						ny = mCurY + 1;
					end
				endcase
				if (!blocked)
				begin
					expectPixel(mCurX, mCurY, colorBlack);
					expectPixel(nx, ny, colorYellow);
					mCurX = nx;
					mCurY = ny;
				end
			end
		end
	endtask

	task automatic modelTicks(input int n);
		int t;
		for (t = 0; t < n; t++)
		begin
			if (!mLost)
			begin
				drawSquare(slotXs[mSlot], slotYs[mSlot], colorBlack);
				drawSquare(mTimer, 11, colorBlack);
				mTimer = mTimer + 5;
				if (mTimer >= 160)
					mLost = 1'b1;
				else
				begin
					mSlot = (mSlot + 1) % 7;
					drawSquare(slotXs[mSlot], slotYs[mSlot], colorCyan);
				end
			end
		end
	endtask

	task automatic checkWrite();
		fbAddr a;
		pixelColor c;
		if (expAddr.size() == 0)
		begin
			$display("unexpected pixel write at address %0d while none was expected", obsAddr);
			stopOnError();
		end
		else
		begin
			a = expAddr.pop_front();
			c = expColor.pop_front();
			checkAddr(obsAddr, a, "plot address");
			checkColor(obsColor, c, "plot colour");
		end
	endtask

	// drive plotReady for one clock and check the transfer due at the next rising edge
	task automatic stepCycle();
		@(negedge clk);
		if (randomReady)
			plotReady = (takeBits(1) == 1);
		else
			plotReady = 1'b1;
		if (resetn && obsValid && plotReady)
			checkWrite();
	endtask

	task automatic resetDut();
		resetn = 1'b0;
		start = 1'b0;
		scanValid = 1'b0;
		expAddr.delete();
		expColor.delete();
		mCurX = 80;
		mCurY = 60;
		mSlot = 0;
		mTimer = 0;
		mWon = 1'b0;
		mLost = 1'b0;
		repeat (3) stepCycle();
		resetn = 1'b1;
		checkFlag(obsValid, 1'b0, "plotValid after reset");
		checkFlag(obsWon, 1'b0, "won after reset");
		checkFlag(obsLost, 1'b0, "lost after reset");
		checkFlag(obsScanReady, 1'b1, "scanReady after reset");
	endtask

	task automatic startGame();
		start = 1'b1;
		drawSquare(slotXs[0], slotYs[0], colorCyan);
		expectPixel(mCurX, mCurY, colorYellow);
		stepCycle();
		start = 1'b0;
	endtask

	task automatic sendKey(input int kind);
		int gap;
		scanData = codeFor(kind);
		scanValid = 1'b1;
		while (!dutScanReady)
			stepCycle();
		modelKey(kind);
		stepCycle();
		scanValid = 1'b0;
		gap = takeBits(2);
		repeat (gap) stepCycle();
	endtask

	// wait for all expected writes and then a quiet window for strays
	task automatic waitDrain();
		while (expAddr.size() != 0)
			stepCycle();
		repeat (quietCycles) stepCycle();
	endtask

	task automatic introPhase();
		useTick = 1'b0;
		resetDut();
		startGame();
		waitDrain();
		checkFlag(obsWon, 1'b0, "won after intro");
		checkFlag(obsLost, 1'b0, "lost after intro");
	endtask

	task automatic keyPhase();
		int i;
		useTick = 1'b0;
		resetDut();
		startGame();
		// walk into every bound and push past it
		repeat (85) sendKey(kindLeft);
		repeat (165) sendKey(kindRight);
		repeat (45) sendKey(kindUp);
		repeat (105) sendKey(kindDown);
		for (i = 0; i < randomKeys; i++)
		begin
			if (!randomReady)
				keyKinds[i] = randomKind();
			sendKey(keyKinds[i]);
		end
		waitDrain();
		checkFlag(obsWon, mWon, "won after keys");
		checkFlag(obsLost, 1'b0, "lost after keys");
	endtask

	task automatic shootPhase();
		useTick = 1'b0;
		resetDut();
		startGame();
		sendKey(kindShoot);
		waitDrain();
		checkFlag(obsWon, 1'b0, "won after a miss");
		// steer to (27,27) inside slot 0
		repeat (53) sendKey(kindLeft);
		repeat (33) sendKey(kindUp);
		sendKey(kindShoot);
		// free moves and a shoot that the ended game must ignore
		sendKey(kindRight);
		sendKey(kindDown);
		sendKey(kindShoot);
		sendKey(kindLeft);
		waitDrain();
		checkFlag(obsWon, 1'b1, "won after a hit");
		checkFlag(obsLost, 1'b0, "lost after a hit");
	endtask

	task automatic timerPhase();
		useTick = 1'b1;
		resetDut();
		startGame();
		modelTicks(numTicks);
		waitDrain();
		checkFlag(obsLost, 1'b1, "lost after the timer ran out");
		checkFlag(obsWon, 1'b0, "won after the timer ran out");
	endtask

	initial
	begin
		clk = 1'b0;
		resetn = 1'b0;
		start = 1'b0;
		scanData = 8'h00;
		scanValid = 1'b0;
		plotReady = 1'b1;
		useTick = 1'b0;
		randomReady = 1'b0;
		lfsrState = 32'h6208d79d;

		introPhase();
		keyPhase();
		shootPhase();
		timerPhase();

		// same sequences again under a stalling display side
		randomReady = 1'b1;
		keyPhase();
		timerPhase();

		if (errorCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* verilog.f */
gamePkg.sv
pixelStreamIf.sv
keyDecoder.sv
gameEngine.sv
pixelFifo.sv
framePlotter.sv
targetGame.sv
tb_targetGame.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_targetGame
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
SIM ?= Vtb_targetGame
VFLAGS ?= --timescale 1ns/10ps
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(SIM)

run: build
	@out="$$(./$(BUILD_DIR)/$(SIM))"; echo "$$out"; \
		echo "$$out" | grep -q "^TB PASSED$$"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
